//--- vlog.f
hdl/llapi_pkg.sv
hdl/llapi_presence.sv
hdl/llapi_remap.sv
hdl/player_slot_assign.sv
hdl/llapi_input_top.sv
testbench/tb_clock.sv
testbench/llapi_checker.sv
testbench/llapi_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the LLAPI input pipeline testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps --top-module llapi_tb -f vlog.f -o llapi_sim
./obj_dir/llapi_sim > sim.log
cat sim.log
if grep -qx "No errors" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

//--- testbench/llapi_tb.sv
//==============================
// Testbench top for the LLAPI input pipeline
// Applies a table of fixed and random rows, one per clk_sys edge,
// and leaves the comparing to the checker
//==============================

module llapi_tb
	import llapi_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RANDOM_ROWS   = 200;
	localparam int RESET_TIMEOUT = 40;
	localparam int DRAIN_TIMEOUT = 20;

	typedef struct packed {
		llapi_pad_t   pad_a;
		llapi_pad_t   pad_b;
		usb_joys_t    usb;
		serial_mode_e mode;
	} stim_row_t;

	logic         clk_sys;
	logic         reset;
	llapi_pad_t   pad_a;
	llapi_pad_t   pad_b;
	usb_joys_t    usb_joys;
	serial_mode_e serial_mode;
	player_joys_t players;
	logic         menu_request;
	int           errors;
	int           checks;
	int           pushed;
	stim_row_t    rows[$];
	logic [31:0]  rng_state = 32'ha338_3803;
	logic         timed_out = 1'b0;

	// Single and multi button patterns for the remap rows
	logic [31:0] remap_patterns [10] = '{
		32'h0000_0200, 32'h0000_0080, 32'h0000_0100, 32'h0000_0040, 32'h0000_0010,
		32'h0000_0020, 32'h0000_000f, 32'h0f00_0000, 32'h0000_0280, 32'h0a00_03ff
	};

	tb_clock u_clock (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	llapi_input_top uut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.pad_a        (pad_a),
		.pad_b        (pad_b),
		.usb_joys     (usb_joys),
		.serial_mode  (serial_mode),
		.players      (players),
		.menu_request (menu_request)
	);

	llapi_checker u_checker (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.pad_a        (pad_a),
		.pad_b        (pad_b),
		.usb_joys     (usb_joys),
		.serial_mode  (serial_mode),
		.players      (players),
		.menu_request (menu_request),
		.errors       (errors),
		.checks       (checks),
		.pushed       (pushed)
	);

	// ==============================
	// Stimulus helpers
	// ==============================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic llapi_pad_t make_pad(input logic [31:0] buttons, input logic [7:0] ctype,
		input logic en);
		llapi_pad_t p;
		p.buttons   = buttons;
		p.ctrl_type = ctype;
		p.en        = en;
		return p;
	endfunction

	// Plain code 8'h21 takes the upper half of the selector
	function automatic logic [7:0] pick_type(input logic [2:0] sel);
		case (sel)
			3'd0:    return 8'd0;
			3'd1:    return 8'd3;
			3'd2:    return 8'd8;
			3'd3:    return 8'hff;
			default: return 8'h21;
		endcase
	endfunction

	function automatic llapi_pad_t random_pad();
		logic [31:0] sel;
		logic [31:0] btn;
		sel = next_random();
		btn = next_random();
		if (sel[4:3] == 2'b00) btn = '0;
		return make_pad(btn, pick_type(sel[2:0]), sel[7:5] != 3'b000);
	endfunction

	task automatic add_row(input llapi_pad_t a, input llapi_pad_t b, input serial_mode_e m);
		stim_row_t   r;
		logic [31:0] hi;
		logic [31:0] lo;
		hi      = next_random();
		lo      = next_random();
		r.pad_a = a;
		r.pad_b = b;
		r.usb   = {hi[27:0], lo};
		r.mode  = m;
		rows.push_back(r);
	endtask

	task automatic build_table();
		logic [31:0] sel;
		// Type 0 on A and 255 on B count only after a press
		add_row(make_pad(32'h0, 8'd0, 1'b1), make_pad(32'h0, 8'hff, 1'b1), SERIAL_LLAPI);
		add_row(make_pad(32'h1, 8'd0, 1'b1), make_pad(32'h0, 8'hff, 1'b1), SERIAL_LLAPI);
		add_row(make_pad(32'h0, 8'd0, 1'b1), make_pad(32'h0100_0000, 8'hff, 1'b1), SERIAL_LLAPI);
		add_row(make_pad(32'h0, 8'd0, 1'b1), make_pad(32'h0, 8'hff, 1'b1), SERIAL_LLAPI);
		// Only B, then neither
		add_row(make_pad(32'h0, 8'd0, 1'b0), make_pad(32'h0, 8'hff, 1'b1), SERIAL_LLAPI);
		add_row(make_pad(32'h0, 8'd0, 1'b0), make_pad(32'h0, 8'hff, 1'b0), SERIAL_LLAPI);
		// Other serial modes pass the USB words straight through
		add_row(make_pad(32'h0f00_00ff, 8'd3, 1'b1), make_pad(32'hffff_ffff, 8'd8, 1'b1),
			SERIAL_OFF);
		add_row(make_pad(32'h0f00_00ff, 8'd3, 1'b1), make_pad(32'hffff_ffff, 8'd8, 1'b1),
			SERIAL_SNAC_SNES);
		add_row(make_pad(32'h0f00_00ff, 8'd3, 1'b1), make_pad(32'hffff_ffff, 8'd8, 1'b1),
			SERIAL_SNAC_GB);
		for (int i = 0; i < 10; i++) begin
			add_row(make_pad(remap_patterns[i], 8'd3, 1'b1),
				make_pad(remap_patterns[i], 8'h21, 1'b1), SERIAL_LLAPI);
			add_row(make_pad(remap_patterns[i], 8'd8, 1'b1),
				make_pad(remap_patterns[i], 8'h05, 1'b1), SERIAL_LLAPI);
		end
		// Menu combo, also from pads that are not active
		add_row(make_pad(32'h0400_0021, 8'd0, 1'b0), make_pad(32'h0, 8'd3, 1'b1), SERIAL_LLAPI);
		add_row(make_pad(32'h0, 8'd3, 1'b1), make_pad(32'h0400_0021, 8'd8, 1'b0), SERIAL_OFF);
		add_row(make_pad(32'h0400_0020, 8'd3, 1'b1), make_pad(32'h21, 8'd3, 1'b1), SERIAL_LLAPI);
		for (int i = 0; i < RANDOM_ROWS; i++) begin
			sel = next_random();
			add_row(random_pad(), random_pad(),
				sel[2] ? SERIAL_LLAPI : serial_mode_e'(sel[1:0]));
		end
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin : stimulus
		int cycles;
		int target;
		pad_a       = '0;
		pad_b       = '0;
		usb_joys    = '0;
		serial_mode = SERIAL_OFF;
		build_table();
		cycles = 0;
		do begin
			@(posedge clk_sys);
			cycles++;
		end while (reset !== 1'b0 && cycles < RESET_TIMEOUT);
		if (reset !== 1'b0) begin
			$display("reset was still high after %0d cycles", RESET_TIMEOUT);
			timed_out = 1'b1;
		end
		if (!timed_out) begin
			foreach (rows[i]) begin
				@(posedge clk_sys);
				pad_a       <= rows[i].pad_a;
				pad_b       <= rows[i].pad_b;
				usb_joys    <= rows[i].usb;
				serial_mode <= rows[i].mode;
			end
			@(posedge clk_sys);
			@(negedge clk_sys);
			target = pushed;
			cycles = 0;
			while (checks < target && cycles < DRAIN_TIMEOUT) begin
				@(negedge clk_sys);
				cycles++;
			end
			if (checks < target) begin
				$display("pipeline did not drain, %0d of %0d rows checked", checks, target);
				timed_out = 1'b1;
			end
		end
		$display("Checks %0d, errors %0d", checks, errors);
		if (!timed_out && errors == 0 && checks > 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- testbench/llapi_checker.sv
//==============================
// Reference model and checker for the LLAPI input pipeline
// Samples the DUT inputs on every clk_sys edge, predicts players and
// menu_request, and compares them three edges later
//==============================

module llapi_checker
	import llapi_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  llapi_pad_t   pad_a,
	input  llapi_pad_t   pad_b,
	input  usb_joys_t    usb_joys,
	input  serial_mode_e serial_mode,
	input  player_joys_t players,
	input  logic         menu_request,
	output int           errors,
	output int           checks,
	output int           pushed
);

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		player_joys_t players;
		logic         menu;
	} expect_t;

	expect_t expect_q[$];
	logic    pressed_a = 1'b0;
	logic    pressed_b = 1'b0;
	logic    started = 1'b0;
	int      error_count = 0;
	int      check_count = 0;
	int      push_count = 0;

	assign errors = error_count;
	assign checks = check_count;
	assign pushed = push_count;

	// ==============================
	// Expected values
	// ==============================
	function automatic snes_joy_t expected_joy(input logic [31:0] b, input logic [7:0] t);
		snes_joy_t j;
		logic      saturn;
		saturn    = (t == 8'd3) || (t == 8'd8);
		j.start   = b[5];
		j.select  = saturn ? b[6] : b[4];
		j.r       = saturn ? (b[9] | b[7]) : b[7];
		j.l       = saturn ? b[8] : b[6];
		j.y       = b[2];
		j.x       = b[3];
		j.b       = b[0];
		j.a       = b[1];
		j.d_up    = b[27];
		j.d_down  = b[26];
		j.d_left  = b[25];
		j.d_right = b[24];
		return j;
	endfunction

	function automatic logic is_active(input llapi_pad_t p, input logic pressed,
		input serial_mode_e m);
		logic known;
		known = (p.ctrl_type != 8'd0) && (p.ctrl_type != 8'hff);
		return p.en && (m == SERIAL_LLAPI) && (known || pressed);
	endfunction

	function automatic logic menu_combo(input logic [31:0] b);
		return b[26] && b[5] && b[0];
	endfunction

	// Active pads in front, USB words after them in order
	function automatic player_joys_t expected_slots(input snes_joy_t ja, input snes_joy_t jb,
		input logic act_a, input logic act_b, input usb_joys_t u);
		player_joys_t p;
		int           n;
		n = 0;
		if (act_a) n++;
		if (act_b) n++;
		for (int s = 2; s < 5; s++) begin
			p[s] = u[s - n];
		end
		p[0] = act_a ? ja : u[0];
		p[1] = act_b ? jb : u[(n == 0) ? 1 : 0];
		return p;
	endfunction

	task automatic compare_outputs(input expect_t e);
		for (int s = 0; s < 5; s++) begin
			if (players[s] !== e.players[s]) begin
				$display("mismatch players[%0d] expected %h actual %h",
					s, e.players[s], players[s]);
				error_count++;
			end
		end
		if (menu_request !== e.menu) begin
			$display("mismatch menu_request expected %h actual %h", e.menu, menu_request);
			error_count++;
		end
	endtask

	// ==============================
	// Sampling and comparison
	// ==============================
	always @(posedge clk_sys) begin : sample
		expect_t e;
		expect_t due;
		logic    act_a;
		logic    act_b;
		// Outputs seen here were registered on the edge before
		if (started) begin
			if (expect_q.size() == 3) begin
				due = expect_q.pop_front();
				compare_outputs(due);
				check_count++;
			end else begin
				compare_outputs('0);
			end
		end
		started = 1'b1;
		if (reset) begin
			pressed_a = 1'b0;
			pressed_b = 1'b0;
			expect_q.delete();
		end else begin
			act_a     = is_active(pad_a, pressed_a, serial_mode);
			act_b     = is_active(pad_b, pressed_b, serial_mode);
			e.players = expected_slots(expected_joy(pad_a.buttons, pad_a.ctrl_type),
				expected_joy(pad_b.buttons, pad_b.ctrl_type), act_a, act_b, usb_joys);
			e.menu    = menu_combo(pad_a.buttons) || menu_combo(pad_b.buttons);
			expect_q.push_back(e);
			push_count++;
			// Sticky flags move after the decision that used them
			pressed_a = pressed_a || (|pad_a.buttons);
			pressed_b = pressed_b || (|pad_b.buttons);
		end
	end

endmodule

//--- testbench/tb_clock.sv
//==============================
// Clock and reset for the LLAPI pipeline testbench
// clk_sys runs at an 8 ns period, reset is high for the first 10 edges
//==============================

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 10;

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

//--- hdl/llapi_input_top.sv
//==============================
// LLAPI input pipeline, top level
// Two pads go through presence and remap stages, then meet the USB
// joysticks in the slot assigner; latency is three clk_sys cycles
//==============================

module llapi_input_top
	import llapi_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  llapi_pad_t   pad_a,
	input  llapi_pad_t   pad_b,
	input  usb_joys_t    usb_joys,
	input  serial_mode_e serial_mode,
	output player_joys_t players,
	output logic         menu_request
);

	presence_stage_t presence_a;
	presence_stage_t presence_b;
	remap_stage_t    remap_a;
	remap_stage_t    remap_b;

	// ==============================
	// Stage 1, presence
	// ==============================
	llapi_presence u_presence_a (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.pad         (pad_a),
		.serial_mode (serial_mode),
		.stage_out   (presence_a)
	);

	llapi_presence u_presence_b (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.pad         (pad_b),
		.serial_mode (serial_mode),
		.stage_out   (presence_b)
	);

	// ==============================
	// Stage 2, button remap
	// ==============================
	llapi_remap u_remap_a (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.stage_in  (presence_a),
		.stage_out (remap_a)
	);

	llapi_remap u_remap_b (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.stage_in  (presence_b),
		.stage_out (remap_b)
	);

	// Stage 3, player slots and menu combo
	player_slot_assign u_slot_assign (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.pad_a        (remap_a),
		.pad_b        (remap_b),
		.usb_joys     (usb_joys),
		.players      (players),
		.menu_request (menu_request)
	);

endmodule

//--- hdl/player_slot_assign.sv
//==============================
// Stage 3 of the LLAPI input pipeline
// Present LLAPI pads take the first player slots and the USB
// joysticks move up to the next free ones
// USB words are delayed two cycles to line up with the pad words
//==============================

module player_slot_assign
	import llapi_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  remap_stage_t pad_a,
	input  remap_stage_t pad_b,
	input  usb_joys_t    usb_joys,
	output player_joys_t players,
	output logic         menu_request
);

	// USB delay line, matches stages 1 and 2
	usb_joys_t    usb_d1;
	usb_joys_t    usb_d2;
	player_joys_t slots_next;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			usb_d1 <= '0;
			usb_d2 <= '0;
		end else begin
			usb_d1 <= usb_joys;
			usb_d2 <= usb_d1;
		end
	end

	// ==============================
	// Slot selection
	// ==============================
	always_comb begin
		if (pad_a.active && pad_b.active) begin
			slots_next[0] = pad_a.joy;
			slots_next[1] = pad_b.joy;
			slots_next[2] = usb_d2[0];
			slots_next[3] = usb_d2[1];
			slots_next[4] = usb_d2[2];
		end else if (pad_a.active || pad_b.active) begin
			// USB 0 fills whichever LLAPI slot is empty
			slots_next[0] = pad_a.active ? pad_a.joy : usb_d2[0];
			slots_next[1] = pad_b.active ? pad_b.joy : usb_d2[0];
			slots_next[2] = usb_d2[1];
			slots_next[3] = usb_d2[2];
			slots_next[4] = usb_d2[3];
		end else begin
			slots_next = usb_d2;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			players      <= '0;
			menu_request <= 1'b0;
		end else begin
			players      <= slots_next;
			menu_request <= pad_a.osd_combo || pad_b.osd_combo;
		end
	end

endmodule

//--- hdl/llapi_remap.sv
//==============================
// Stage 2 of the LLAPI input pipeline
// Maps one pad's raw buttons onto the 12-bit SNES joystick word
// Saturn pads use Z for select and the triggers for the shoulders
// Also flags the down + start + first button menu combo
//==============================

module llapi_remap
	import llapi_pkg::*;
(
	input  logic            clk_sys,
	input  logic            reset,
	input  presence_stage_t stage_in,
	output remap_stage_t    stage_out
);

	logic [LLAPI_BUTTON_W-1:0] btn;
	logic [SNES_JOY_W-1:0]     joy_next;
	logic                      saturn;
	logic                      combo;

	assign btn = stage_in.buttons;

	assign saturn = (stage_in.ctrl_type == LLAPI_TYPE_SATURN) ||
		(stage_in.ctrl_type == LLAPI_TYPE_SATURN_ALT);

	// Word order is start select r l y x b a up down left right
	always_comb begin
		if (saturn) begin
			// No select button on a Saturn pad, Z stands in
			joy_next = {
				btn[BTN_START], btn[BTN_L],
				btn[BTN_RT] | btn[BTN_R], btn[BTN_LT],
				btn[BTN_Y], btn[BTN_X], btn[BTN_B], btn[BTN_A],
				btn[BTN_UP], btn[BTN_DOWN], btn[BTN_LEFT], btn[BTN_RIGHT]
			};
		end else begin
			joy_next = {
				btn[BTN_START], btn[BTN_SELECT],
				btn[BTN_R], btn[BTN_L],
				btn[BTN_Y], btn[BTN_X], btn[BTN_B], btn[BTN_A],
				btn[BTN_UP], btn[BTN_DOWN], btn[BTN_LEFT], btn[BTN_RIGHT]
			};
		end
	end

	// Menu combo is taken from any pad, present or not
	assign combo = btn[BTN_DOWN] && btn[BTN_START] && btn[BTN_B];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stage_out <= '0;
		end else begin
			stage_out.joy       <= snes_joy_t'(joy_next);
			stage_out.active    <= stage_in.active;
			stage_out.osd_combo <= combo;
		end
	end

endmodule

//--- hdl/llapi_presence.sv
//==============================
// Stage 1 of the LLAPI input pipeline
// Samples one pad and decides whether a controller is really there
// A type of 0 or 255 only counts once a button has been seen
//==============================

module llapi_presence
	import llapi_pkg::*;
(
	input  logic            clk_sys,
	input  logic            reset,
	input  llapi_pad_t      pad,
	input  serial_mode_e    serial_mode,
	output presence_stage_t stage_out
);

	// Sticky flag, set by any button and kept until reset
	logic pressed;

	logic any_button;
	logic type_known;
	logic llapi_selected;
	logic active_next;

	// ==============================
	// Presence decision
	// ==============================
	assign any_button = |pad.buttons;

	// Type 0 is an Atari pad or nothing, 255 is a bad read
	assign type_known = (pad.ctrl_type != LLAPI_TYPE_NONE) &&
		(pad.ctrl_type != LLAPI_TYPE_INVALID);

	assign llapi_selected = (serial_mode == SERIAL_LLAPI);

	// Uses the flag as it was before this edge
	assign active_next = pad.en && llapi_selected && (type_known || pressed);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pressed <= 1'b0;
		end else if (any_button) begin
			pressed <= 1'b1;
		end
	end

	// ==============================
	// Stage register
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stage_out <= '0;
		end else begin
			stage_out.buttons   <= pad.buttons;
			stage_out.ctrl_type <= pad.ctrl_type;
			stage_out.active    <= active_next;
		end
	end

endmodule

//--- hdl/llapi_pkg.sv
//==============================
// Shared definitions for the LLAPI input pipeline
// Widths, controller type codes, raw button indices, the serial mode
// enum and the structs passed between the three stages
// Imported by every RTL module of the pipeline
//==============================

package llapi_pkg;

	// ==============================
	// Widths and sizes
	// ==============================
	localparam int LLAPI_BUTTON_W = 32;
	localparam int LLAPI_TYPE_W   = 8;
	localparam int SNES_JOY_W     = 12;
	localparam int NUM_PLAYERS    = 5;

	// Controller type codes reported by the LLAPI engine
	localparam logic [LLAPI_TYPE_W-1:0] LLAPI_TYPE_NONE       = 8'd0;
	localparam logic [LLAPI_TYPE_W-1:0] LLAPI_TYPE_SATURN     = 8'd3;
	localparam logic [LLAPI_TYPE_W-1:0] LLAPI_TYPE_SATURN_ALT = 8'd8;
	localparam logic [LLAPI_TYPE_W-1:0] LLAPI_TYPE_INVALID    = 8'hff;

	// Raw button indices, HID usage minus one
	localparam int BTN_B      = 0;
	localparam int BTN_A      = 1;
	localparam int BTN_Y      = 2;
	localparam int BTN_X      = 3;
	localparam int BTN_SELECT = 4;
	localparam int BTN_START  = 5;
	// On a Saturn pad BTN_L is the Z button
	localparam int BTN_L      = 6;
	localparam int BTN_R      = 7;
	localparam int BTN_LT     = 8;
	localparam int BTN_RT     = 9;
	localparam int BTN_RIGHT  = 24;
	localparam int BTN_LEFT   = 25;
	localparam int BTN_DOWN   = 26;
	localparam int BTN_UP     = 27;

	// User port serial modes from the menu
	typedef enum logic [1:0] {
		SERIAL_OFF       = 2'd0,
		SERIAL_SNAC_SNES = 2'd1,
		SERIAL_SNAC_GB   = 2'd2,
		SERIAL_LLAPI     = 2'd3
	} serial_mode_e;

	// ==============================
	// Pipeline structs
	// ==============================
	typedef struct packed {
		logic [LLAPI_BUTTON_W-1:0] buttons;
		logic [LLAPI_TYPE_W-1:0]   ctrl_type;
		logic                      en;
	} llapi_pad_t;

	typedef struct packed {
		logic start;
		logic select;
		logic r;
		logic l;
		logic y;
		logic x;
		logic b;
		logic a;
		logic d_up;
		logic d_down;
		logic d_left;
		logic d_right;
	} snes_joy_t;

	typedef struct packed {
		logic [LLAPI_BUTTON_W-1:0] buttons;
		logic [LLAPI_TYPE_W-1:0]   ctrl_type;
		logic                      active;
	} presence_stage_t;

	typedef struct packed {
		snes_joy_t joy;
		logic      active;
		logic      osd_combo;
	} remap_stage_t;

	typedef snes_joy_t [NUM_PLAYERS-1:0] usb_joys_t;
	typedef snes_joy_t [NUM_PLAYERS-1:0] player_joys_t;

endpackage
